// ==== hdl/axi_bridge_pkg.sv ====
`default_nettype none

package axi_bridge_pkg;

    // byte address on both the SRAM-like side and the AXI side
    typedef logic [31:0] addr_t;

    // one data word, always a full word on reads
    typedef logic [31:0] word_t;

    // byte lane enables, bit i covers bits 8*i+7 .. 8*i
    typedef logic [3:0] strb_t;

    // AXI transaction id
    typedef logic [3:0] axi_id_t;

    // instruction fetch
    localparam axi_id_t ID_INST = 4'd0;

    // data port read or write
    localparam axi_id_t ID_DATA = 4'd1;

endpackage

`default_nettype wire

// ==== hdl/sram_req_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_req_arbiter (
    input  wire                            clk,
    input  wire                            resetn,
    // instruction port, reads only
    input  wire                            inst_req,
    input  wire axi_bridge_pkg::addr_t     inst_addr,
    output logic                           inst_addr_ok,
    // data port
    input  wire                            data_req,
    input  wire                            data_wr,
    input  wire axi_bridge_pkg::addr_t     data_addr,
    input  wire axi_bridge_pkg::word_t     data_wdata,
    input  wire axi_bridge_pkg::strb_t     data_wstrb,
    output logic                           data_addr_ok,
    // one-entry slot towards the issue stage
    output logic                           slot_valid,
    output logic                           slot_wr,
    output axi_bridge_pkg::axi_id_t        slot_id,
    output axi_bridge_pkg::addr_t          slot_addr,
    output axi_bridge_pkg::word_t          slot_wdata,
    output axi_bridge_pkg::strb_t          slot_wstrb,
    input  wire                            slot_ready
);

    logic data_take;
    logic inst_take;
    logic slot_pop;

    // data port wins a tie, instruction only gets through when data is quiet
    assign data_addr_ok = !slot_valid;
    assign inst_addr_ok = !slot_valid && !data_req;

    assign data_take = data_req && data_addr_ok;
    assign inst_take = inst_req && inst_addr_ok;
    assign slot_pop  = slot_valid && slot_ready;

    // occupancy of the slot
    always_ff @(posedge clk) begin
        if (!resetn) begin
            slot_valid <= 1'b0;
        end else if (slot_pop) begin
            slot_valid <= 1'b0;
        end else if (data_take || inst_take) begin
            slot_valid <= 1'b1;
        end
    end

    // entry payload, only meaningful while slot_valid is high
    always_ff @(posedge clk) begin
        if (data_take) begin
            slot_wr    <= data_wr;
            slot_id    <= axi_bridge_pkg::ID_DATA;
            slot_addr  <= data_addr;
            slot_wdata <= data_wdata;
            slot_wstrb <= data_wstrb;
        end else if (inst_take) begin
            slot_wr    <= 1'b0;
            slot_id    <= axi_bridge_pkg::ID_INST;
            slot_addr  <= inst_addr;
            // fetches never write
            slot_wstrb <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/axi_master_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_master_issue (
    input  wire                            clk,
    input  wire                            resetn,
    // entry from the arbiter
    input  wire                            slot_valid,
    input  wire                            slot_wr,
    input  wire axi_bridge_pkg::axi_id_t   slot_id,
    input  wire axi_bridge_pkg::addr_t     slot_addr,
    input  wire axi_bridge_pkg::word_t     slot_wdata,
    input  wire axi_bridge_pkg::strb_t     slot_wstrb,
    output logic                           slot_ready,
    // read address channel
    output logic                           arvalid,
    input  wire                            arready,
    output axi_bridge_pkg::axi_id_t        arid,
    output axi_bridge_pkg::addr_t          araddr,
    // write address channel
    output logic                           awvalid,
    input  wire                            awready,
    output axi_bridge_pkg::axi_id_t        awid,
    output axi_bridge_pkg::addr_t          awaddr,
    // write data channel
    output logic                           wvalid,
    input  wire                            wready,
    output axi_bridge_pkg::word_t          wdata,
    output axi_bridge_pkg::strb_t          wstrb
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE
    } state_t;

    state_t                  state;
    logic                    aw_done;
    logic                    w_done;
    logic                    aw_last;
    logic                    w_last;
    axi_bridge_pkg::axi_id_t id_q;
    axi_bridge_pkg::addr_t   addr_q;
    axi_bridge_pkg::word_t   wdata_q;
    axi_bridge_pkg::strb_t   wstrb_q;

    assign slot_ready = (state == S_IDLE);

    assign arvalid = (state == S_READ);
    assign awvalid = (state == S_WRITE) && !aw_done;
    assign wvalid  = (state == S_WRITE) && !w_done;

    // each write channel is finished once it has been or is being accepted
    assign aw_last = aw_done || awready;
    assign w_last  = w_done || wready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= S_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (slot_valid) begin
                        state   <= slot_wr ? S_WRITE : S_READ;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                S_READ: begin
                    if (arready) begin
                        state <= S_IDLE;
                    end
                end
                S_WRITE: begin
                    // AW and W may be accepted in either order
                    if (awvalid && awready) begin
                        aw_done <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        w_done <= 1'b1;
                    end
                    if (aw_last && w_last) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // hold the entry stable for the whole handshake
    always_ff @(posedge clk) begin
        if (slot_valid && slot_ready) begin
            id_q    <= slot_id;
            addr_q  <= slot_addr;
            wdata_q <= slot_wdata;
            wstrb_q <= slot_wstrb;
        end
    end

    assign arid   = id_q;
    assign araddr = addr_q;
    assign awid   = id_q;
    assign awaddr = addr_q;
    assign wdata  = wdata_q;
    assign wstrb  = wstrb_q;

endmodule

`default_nettype wire

// ==== hdl/axi_resp_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_resp_router (
    input  wire                            clk,
    input  wire                            resetn,
    // read response channel
    input  wire                            rvalid,
    input  wire axi_bridge_pkg::axi_id_t   rid,
    input  wire axi_bridge_pkg::word_t     rdata,
    output logic                           rready,
    // write response channel
    input  wire                            bvalid,
    input  wire axi_bridge_pkg::axi_id_t   bid,
    output logic                           bready,
    // results back to the core
    output logic                           inst_data_ok,
    output axi_bridge_pkg::word_t          inst_rdata,
    output logic                           data_data_ok,
    output axi_bridge_pkg::word_t          data_rdata
);

    logic                    r_full;
    logic                    r_inst;
    logic                    b_done;
    axi_bridge_pkg::word_t   rdata_q;

    // holding register is empty except in the pulse cycle
    assign rready = !r_full;
    assign bready = !b_done;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            r_full <= 1'b0;
            b_done <= 1'b0;
        end else begin
            r_full <= rvalid && rready;
            // only the data port writes, so any B goes back there
            b_done <= bvalid && bready && (bid == axi_bridge_pkg::ID_DATA);
        end
    end

    // beat and its owner
    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            rdata_q <= rdata;
            r_inst  <= (rid == axi_bridge_pkg::ID_INST);
        end
    end

    assign inst_data_ok = r_full && r_inst;
    assign data_data_ok = (r_full && !r_inst) || b_done;

    assign inst_rdata = rdata_q;
    assign data_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/axi_sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_sram_slave #(
    parameter int MEM_WORDS  = 1024,
    parameter int RESP_DELAY = 2
) (
    input  wire                            clk,
    input  wire                            resetn,
    // read address channel
    input  wire                            arvalid,
    output logic                           arready,
    input  wire axi_bridge_pkg::axi_id_t   arid,
    input  wire axi_bridge_pkg::addr_t     araddr,
    // write address and data channels
    input  wire                            awvalid,
    output logic                           awready,
    input  wire axi_bridge_pkg::axi_id_t   awid,
    input  wire axi_bridge_pkg::addr_t     awaddr,
    input  wire                            wvalid,
    output logic                           wready,
    input  wire axi_bridge_pkg::word_t     wdata,
    input  wire axi_bridge_pkg::strb_t     wstrb,
    // responses
    output logic                           rvalid,
    input  wire                            rready,
    output axi_bridge_pkg::axi_id_t        rid,
    output axi_bridge_pkg::word_t          rdata,
    output logic                           bvalid,
    input  wire                            bready,
    output axi_bridge_pkg::axi_id_t        bid
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (RESP_DELAY > 1) ? $clog2(RESP_DELAY) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_RESP
    } state_t;

    state_t                  state;
    logic [CNT_W-1:0]        cnt;
    logic                    is_wr;
    logic                    wr_take;
    logic                    rd_take;
    logic [IDX_W-1:0]        widx;
    logic [IDX_W-1:0]        ridx;
    axi_bridge_pkg::axi_id_t id_q;
    axi_bridge_pkg::word_t   rdata_q;
    axi_bridge_pkg::word_t   mem [MEM_WORDS];

    // a write needs AW and W together and beats a pending read
    assign awready = (state == S_IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign arready = (state == S_IDLE) && !(awvalid && wvalid);

    assign wr_take = awready;
    assign rd_take = arvalid && arready;

    // word index wraps around the memory depth
    assign widx = IDX_W'((awaddr >> 2) % MEM_WORDS);
    assign ridx = IDX_W'((araddr >> 2) % MEM_WORDS);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_IDLE;
            cnt   <= '0;
            is_wr <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (wr_take || rd_take) begin
                        is_wr <= wr_take;
                        cnt   <= CNT_W'(RESP_DELAY - 1);
                        state <= (RESP_DELAY > 1) ? S_WAIT : S_RESP;
                    end
                end
                S_WAIT: begin
                    if (cnt == CNT_W'(1)) begin
                        state <= S_RESP;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_RESP: begin
                    if ((rvalid && rready) || (bvalid && bready)) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // storage, write lanes and read sample happen at acceptance
    always_ff @(posedge clk) begin
        if (wr_take) begin
            id_q <= awid;
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[widx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end else if (rd_take) begin
            id_q    <= arid;
            rdata_q <= mem[ridx];
        end
    end

    assign rvalid = (state == S_RESP) && !is_wr;
    assign bvalid = (state == S_RESP) && is_wr;
    assign rid    = id_q;
    assign bid    = id_q;
    assign rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/cpu_axi_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_axi_subsystem #(
    parameter int MEM_WORDS  = 1024,
    parameter int RESP_DELAY = 2
) (
    input  wire                            clk,
    input  wire                            resetn,
    // instruction port
    input  wire                            inst_req,
    input  wire axi_bridge_pkg::addr_t     inst_addr,
    output wire                            inst_addr_ok,
    output wire                            inst_data_ok,
    output axi_bridge_pkg::word_t          inst_rdata,
    // data port
    input  wire                            data_req,
    input  wire                            data_wr,
    input  wire axi_bridge_pkg::addr_t     data_addr,
    input  wire axi_bridge_pkg::word_t     data_wdata,
    input  wire axi_bridge_pkg::strb_t     data_wstrb,
    output wire                            data_addr_ok,
    output wire                            data_data_ok,
    output axi_bridge_pkg::word_t          data_rdata
);

    // arbiter to issue stage
    wire                            slot_valid;
    wire                            slot_ready;
    wire                            slot_wr;
    wire axi_bridge_pkg::axi_id_t   slot_id;
    wire axi_bridge_pkg::addr_t     slot_addr;
    wire axi_bridge_pkg::word_t     slot_wdata;
    wire axi_bridge_pkg::strb_t     slot_wstrb;

    // AXI between issue stage, memory and router
    wire                            arvalid;
    wire                            arready;
    wire axi_bridge_pkg::axi_id_t   arid;
    wire axi_bridge_pkg::addr_t     araddr;
    wire                            awvalid;
    wire                            awready;
    wire axi_bridge_pkg::axi_id_t   awid;
    wire axi_bridge_pkg::addr_t     awaddr;
    wire                            wvalid;
    wire                            wready;
    wire axi_bridge_pkg::word_t     wdata;
    wire axi_bridge_pkg::strb_t     wstrb;
    wire                            rvalid;
    wire                            rready;
    wire axi_bridge_pkg::axi_id_t   rid;
    wire axi_bridge_pkg::word_t     rdata;
    wire                            bvalid;
    wire                            bready;
    wire axi_bridge_pkg::axi_id_t   bid;

    sram_req_arbiter i_arbiter (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_wstrb   (data_wstrb),
        .data_addr_ok (data_addr_ok),
        .slot_valid   (slot_valid),
        .slot_wr      (slot_wr),
        .slot_id      (slot_id),
        .slot_addr    (slot_addr),
        .slot_wdata   (slot_wdata),
        .slot_wstrb   (slot_wstrb),
        .slot_ready   (slot_ready)
    );

    axi_master_issue i_issue (
        .clk        (clk),
        .resetn     (resetn),
        .slot_valid (slot_valid),
        .slot_wr    (slot_wr),
        .slot_id    (slot_id),
        .slot_addr  (slot_addr),
        .slot_wdata (slot_wdata),
        .slot_wstrb (slot_wstrb),
        .slot_ready (slot_ready),
        .arvalid    (arvalid),
        .arready    (arready),
        .arid       (arid),
        .araddr     (araddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .awid       (awid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb)
    );

    axi_sram_slave #(
        .MEM_WORDS  (MEM_WORDS),
        .RESP_DELAY (RESP_DELAY)
    ) i_mem (
        .clk     (clk),
        .resetn  (resetn),
        .arvalid (arvalid),
        .arready (arready),
        .arid    (arid),
        .araddr  (araddr),
        .awvalid (awvalid),
        .awready (awready),
        .awid    (awid),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bid     (bid)
    );

    axi_resp_router i_router (
        .clk          (clk),
        .resetn       (resetn),
        .rvalid       (rvalid),
        .rid          (rid),
        .rdata        (rdata),
        .rready       (rready),
        .bvalid       (bvalid),
        .bid          (bid),
        .bready       (bready),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata)
    );

endmodule

`default_nettype wire

// ==== bench/tb_cpu_axi.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_axi;

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 100;

    logic                    clk;
    logic                    resetn;
    logic                    inst_req;
    axi_bridge_pkg::addr_t   inst_addr;
    logic                    data_req;
    logic                    data_wr;
    axi_bridge_pkg::addr_t   data_addr;
    axi_bridge_pkg::word_t   data_wdata;
    axi_bridge_pkg::strb_t   data_wstrb;
    wire                     inst_addr_ok;
    wire                     inst_data_ok;
    wire axi_bridge_pkg::word_t inst_rdata;
    wire                     data_addr_ok;
    wire                     data_data_ok;
    wire axi_bridge_pkg::word_t data_rdata;

    logic [31:0]             lfsr_state;
    axi_bridge_pkg::word_t   ref_mem [MEM_WORDS];
    axi_bridge_pkg::addr_t   written [$];
    int                      errors;
    int                      tests_passed;
    int                      tests_failed;

    cpu_axi_subsystem i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_wstrb   (data_wstrb),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int word_index(input axi_bridge_pkg::addr_t addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    task automatic send_request(input logic inst, input logic wr,
                                input axi_bridge_pkg::addr_t addr,
                                input axi_bridge_pkg::word_t wd, input axi_bridge_pkg::strb_t st);
        int  n;
        logic got;
        n = 0;
        got = 1'b0;
        @(posedge clk);
        if (inst) begin
            inst_req  <= 1'b1;
            inst_addr <= addr;
        end else begin
            data_req   <= 1'b1;
            data_wr    <= wr;
            data_addr  <= addr;
            data_wdata <= wd;
            data_wstrb <= st;
        end
        while (!got && n < TIMEOUT) begin
            @(negedge clk);
            if (inst ? inst_addr_ok : data_addr_ok) got = 1'b1;
            else n++;
        end
        // handshake happens on this edge
        @(posedge clk);
        inst_req <= 1'b0;
        data_req <= 1'b0;
        if (!got) begin
            errors++;
            $display("request to address %h was never accepted", addr);
        end
    endtask

    task automatic wait_data_ok(input logic inst, input logic check_other,
                                output axi_bridge_pkg::word_t rd);
        int  n;
        logic seen;
        n = 0;
        seen = 1'b0;
        rd = 'x;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            if (check_other && (inst ? data_data_ok : inst_data_ok)) begin
                errors++;
                $display("data_ok pulsed on the wrong port");
            end
            if (inst ? inst_data_ok : data_data_ok) begin
                seen = 1'b1;
                rd = inst ? inst_rdata : data_rdata;
            end else begin
                n++;
            end
        end
        if (!seen) begin
            errors++;
            $display("no data_ok arrived on the %s port", inst ? "instruction" : "data");
        end
    endtask

    task automatic data_write(input axi_bridge_pkg::addr_t addr, input axi_bridge_pkg::word_t wd,
                              input axi_bridge_pkg::strb_t st);
        axi_bridge_pkg::word_t rd;
        send_request(1'b0, 1'b1, addr, wd, st);
        wait_data_ok(1'b0, 1'b1, rd);
        for (int i = 0; i < 4; i++) begin
            if (st[i]) ref_mem[word_index(addr)][8*i +: 8] = wd[8*i +: 8];
        end
    endtask

    task automatic read_check(input logic inst, input axi_bridge_pkg::addr_t addr);
        axi_bridge_pkg::word_t rd;
        axi_bridge_pkg::word_t exp;
        exp = ref_mem[word_index(addr)];
        send_request(inst, 1'b0, addr, '0, '0);
        wait_data_ok(inst, 1'b1, rd);
        if (rd !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h (address %h)",
                     inst ? "inst_rdata" : "data_rdata", rd, exp, addr);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic idle_after_reset();
        int e;
        e = errors;
        repeat (5) begin
            @(negedge clk);
            if (inst_addr_ok !== 1'b1 || data_addr_ok !== 1'b1) begin
                errors++;
                $display("Error: inst_addr_ok = %h, data_addr_ok = %h, expected 1 and 1",
                         inst_addr_ok, data_addr_ok);
            end
            if (inst_data_ok !== 1'b0 || data_data_ok !== 1'b0) begin
                errors++;
                $display("Error: inst_data_ok = %h, data_data_ok = %h, expected 0 and 0",
                         inst_data_ok, data_data_ok);
            end
        end
        finish_test("reset state", e);
    endtask

    task automatic write_then_read();
        int e;
        axi_bridge_pkg::addr_t a;
        e = errors;
        for (int i = 0; i < 8; i++) begin
            a = rand_bits(30) << 2;
            written.push_back(a);
            data_write(a, rand_bits(32), 4'hf);
        end
        foreach (written[i]) read_check(1'b0, written[i]);
        finish_test("data write and read", e);
    endtask

    task automatic partial_writes();
        int e;
        axi_bridge_pkg::addr_t a;
        axi_bridge_pkg::word_t wd;
        axi_bridge_pkg::strb_t st;
        e = errors;
        for (int i = 0; i < 6; i++) begin
            a  = written[rand_bits(3)];
            wd = rand_bits(32);
            st = 4'(rand_bits(4));
            data_write(a, wd, st);
            read_check(1'b0, a);
        end
        finish_test("partial writes", e);
    endtask

    task automatic inst_fetch();
        int e;
        e = errors;
        foreach (written[i]) read_check(1'b1, written[i]);
        finish_test("instruction read", e);
    endtask

    task automatic port_priority();
        int e;
        int n;
        logic got;
        axi_bridge_pkg::word_t rd_d;
        axi_bridge_pkg::word_t rd_i;
        e = errors;
        n = 0;
        got = 1'b0;
        @(posedge clk);
        data_req  <= 1'b1;
        data_wr   <= 1'b0;
        data_addr <= written[0];
        inst_req  <= 1'b1;
        inst_addr <= written[1];
        @(negedge clk);
        if (inst_addr_ok !== 1'b0 || data_addr_ok !== 1'b1) begin
            errors++;
            $display("Error: inst_addr_ok = %h, data_addr_ok = %h, expected 0 and 1",
                     inst_addr_ok, data_addr_ok);
        end
        @(posedge clk);
        data_req <= 1'b0;
        fork
            wait_data_ok(1'b0, 1'b0, rd_d);
            begin
                // instruction request held until the arbiter takes it
                while (!got && n < TIMEOUT) begin
                    @(negedge clk);
                    if (inst_addr_ok) got = 1'b1;
                    else n++;
                end
                @(posedge clk);
                inst_req <= 1'b0;
                if (!got) begin
                    errors++;
                    $display("held instruction request was never accepted");
                end
                wait_data_ok(1'b1, 1'b0, rd_i);
            end
        join
        if (rd_d !== ref_mem[word_index(written[0])]) begin
            errors++;
            $display("Error: data_rdata = %h, expected %h",
                     rd_d, ref_mem[word_index(written[0])]);
        end
        if (rd_i !== ref_mem[word_index(written[1])]) begin
            errors++;
            $display("Error: inst_rdata = %h, expected %h",
                     rd_i, ref_mem[word_index(written[1])]);
        end
        finish_test("priority", e);
    endtask

    task automatic pipelined_reads();
        int e;
        int n;
        axi_bridge_pkg::word_t rd;
        axi_bridge_pkg::word_t got_words [$];
        e = errors;
        fork
            begin
                @(posedge clk);
                data_req  <= 1'b1;
                data_wr   <= 1'b0;
                data_addr <= written[2];
                @(negedge clk);
                for (int i = 0; i < 4; i++) begin
                    n = 0;
                    while (!data_addr_ok && n < TIMEOUT) begin
                        @(negedge clk);
                        if (!data_addr_ok) n++;
                    end
                    if (n >= TIMEOUT) begin
                        errors++;
                        $display("pipelined read %0d was never accepted", i);
                    end
                    @(posedge clk);
                    if (i < 3) data_addr <= written[3 + i];
                    else data_req <= 1'b0;
                    @(negedge clk);
                end
            end
            for (int k = 0; k < 4; k++) begin
                wait_data_ok(1'b0, 1'b1, rd);
                got_words.push_back(rd);
            end
        join
        foreach (got_words[i]) begin
            if (got_words[i] !== ref_mem[word_index(written[2 + i])]) begin
                errors++;
                $display("Error: data_rdata = %h, expected %h (read %0d)",
                         got_words[i], ref_mem[word_index(written[2 + i])], i);
            end
        end
        finish_test("pipelined reads", e);
    endtask

    initial begin
        resetn       = 1'b0;
        inst_req     = 1'b0;
        inst_addr    = '0;
        data_req     = 1'b0;
        data_wr      = 1'b0;
        data_addr    = '0;
        data_wdata   = '0;
        data_wstrb   = '0;
        lfsr_state   = 32'h3eb00846;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;

        idle_after_reset();
        write_then_read();
        partial_writes();
        inst_fetch();
        port_priority();
        pipelined_reads();

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/axi_bridge_pkg.sv
hdl/sram_req_arbiter.sv
hdl/axi_master_issue.sv
hdl/axi_resp_router.sv
hdl/axi_sram_slave.sv
hdl/cpu_axi_subsystem.sv
bench/tb_cpu_axi.sv
